// File: filelist.f
src/nic_pkg.sv
src/nic_axil_slave.sv
src/nic_regs.sv
src/nic_intr_ctrl.sv
src/nic_mdio_master.sv
src/nic_top.sv
testbench/nic_axil_sva.sv
testbench/nic_checker.sv
testbench/tb_nic.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the NIC register-space testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_nic \
	-f filelist.f -o sim_nic
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_nic +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

// File: src/nic_axil_slave.sv
`timescale 1ns/1ps
`default_nettype none

module nic_axil_slave (
	input  logic                aclk,
	input  logic                arst_n_i,

	input  nic_pkg::axil_addr_t s_awaddr_i,
	input  logic                s_awvalid_i,
	output logic                s_awready_o,

	input  nic_pkg::axil_data_t s_wdata_i,
	input  logic [3:0]          s_wstrb_i,
	input  logic                s_wvalid_i,
	output logic                s_wready_o,

	output logic                s_bvalid_o,
	output logic [1:0]          s_bresp_o,
	input  logic                s_bready_i,

	input  nic_pkg::axil_addr_t s_araddr_i,
	input  logic                s_arvalid_i,
	output logic                s_arready_o,

	output logic                s_rvalid_o,
	output nic_pkg::axil_data_t s_rdata_o,
	output logic [1:0]          s_rresp_o,
	input  logic                s_rready_i,

	output nic_pkg::reg_req_t   req_o,
	input  nic_pkg::axil_data_t rdata_i
);
	import nic_pkg::*;

	logic       wr_acc;
	logic       rd_acc;
	logic       bvalid_q;
	logic       rvalid_q;
	axil_data_t rdata_q;

	// AW and W taken together, write wins over read
	assign wr_acc = s_awvalid_i & s_wvalid_i & ~bvalid_q;
	assign rd_acc = s_arvalid_i & ~rvalid_q & ~wr_acc;

	assign s_awready_o = wr_acc;
	assign s_wready_o  = wr_acc;
	assign s_arready_o = rd_acc;

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = 2'b00; // Always OKAY
	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = rdata_q;
	assign s_rresp_o  = 2'b00;

	always_comb begin
		req_o.valid = wr_acc | rd_acc;
		req_o.write = wr_acc;
		req_o.addr  = wr_acc ? s_awaddr_i : s_araddr_i;
		req_o.wdata = s_wdata_i;
		req_o.wstrb = s_wstrb_i;
	end

	// Pending responses
	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (s_bready_i)
				bvalid_q <= 1'b0;

			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (s_rready_i)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (rd_acc)
			rdata_q <= rdata_i; // Held until rready
	end

endmodule

`default_nettype wire

// File: src/nic_intr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module nic_intr_ctrl (
	input  logic                aclk,
	input  logic                arst_n_i,
	input  nic_pkg::intr_cmd_t  cmd_i,
	input  logic                mdac_i,
	input  logic                phy_int_i,
	output nic_pkg::intr_stat_t stat_o,
	output logic                intr_o
);
	import nic_pkg::*;

	logic [1:0] phy_sync_q;
	axil_data_t icr_q;
	axil_data_t ims_q;
	axil_data_t icr_set;
	logic       intr_q;

	// Hardware causes plus software ICS
	always_comb begin
		icr_set                 = cmd_i.ics_set ? cmd_i.data : '0;
		icr_set[ICR_MDAC_BIT]   = icr_set[ICR_MDAC_BIT] | mdac_i;
		icr_set[ICR_PHYINT_BIT] = icr_set[ICR_PHYINT_BIT] | phy_sync_q[1];
	end

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			phy_sync_q <= '0;
			icr_q      <= '0;
			ims_q      <= '0;
			intr_q     <= 1'b0;
		end else begin
			phy_sync_q <= {phy_sync_q[0], phy_int_i};
			icr_q      <= (cmd_i.icr_rd ? '0 : icr_q) | icr_set; // New causes survive a read
			if (cmd_i.ims_set)
				ims_q <= ims_q | cmd_i.data;
			else if (cmd_i.imc_set)
				ims_q <= ims_q & ~cmd_i.data;
			intr_q <= |(icr_q & ims_q);
		end
	end

	assign stat_o.icr = icr_q;
	assign stat_o.ims = ims_q;
	assign intr_o     = intr_q;

endmodule

`default_nettype wire

// File: src/nic_mdio_master.sv
`timescale 1ns/1ps
`default_nettype none

module nic_mdio_master #(
	parameter logic [4:0] PHY_ADDR = 5'd0,
	parameter int         MDC_DIV  = 2
) (
	input  logic               aclk,
	input  logic               arst_n_i,
	input  nic_pkg::mdio_cmd_t cmd_i,
	output nic_pkg::mdio_rsp_t rsp_o,
	output logic               mdc_o,
	input  logic               mdio_i,
	output logic               mdio_o,
	output logic               mdio_oe_o
);
	import nic_pkg::*;

	localparam int DIV_W = $clog2(MDC_DIV + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PRE,
		ST_FRAME
	} state_e;

	state_e           state_q;
	logic [DIV_W-1:0] div_cnt_q;
	logic [4:0]       bit_cnt_q;
	logic             mdc_q;
	logic             mdio_q;
	logic             oe_q;
	logic             done_q;
	logic [31:0]      shift_q;
	logic [15:0]      rdata_q;
	mdio_op_e         op_q;
	logic             tick;
	logic             fall;
	logic             rise;
	logic             last_bit;

	assign tick     = state_q != ST_IDLE && div_cnt_q == DIV_W'(MDC_DIV - 1);
	assign fall     = tick & mdc_q;
	assign rise     = tick & ~mdc_q;
	assign last_bit = bit_cnt_q == 5'd31;

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= ST_IDLE;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
			mdc_q     <= 1'b0;
			mdio_q    <= 1'b1;
			oe_q      <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q    <= 1'b0;
			div_cnt_q <= (state_q == ST_IDLE || tick) ? '0 : div_cnt_q + 1'b1;
			if (tick)
				mdc_q <= ~mdc_q;
			if (state_q == ST_IDLE && cmd_i.start) begin
				state_q   <= ST_PRE;
				bit_cnt_q <= '0;
				mdio_q    <= 1'b1; // Preamble ones
				oe_q      <= 1'b1;
			end else if (fall) begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
				if (state_q == ST_PRE) begin
					if (last_bit) begin
						state_q <= ST_FRAME;
						mdio_q  <= shift_q[31];
					end
				end else if (last_bit) begin
					state_q <= ST_IDLE;
					mdio_q  <= 1'b1;
					oe_q    <= 1'b0;
					done_q  <= 1'b1;
				end else begin
					mdio_q <= shift_q[31];
					if (op_q == MDIO_READ && bit_cnt_q == 5'd13)
						oe_q <= 1'b0; // Release from turnaround
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (state_q == ST_IDLE && cmd_i.start) begin
			shift_q <= {2'b01, cmd_i.op, PHY_ADDR, cmd_i.reg_addr, 2'b10, cmd_i.wdata};
			op_q    <= cmd_i.op;
		end else if (fall && (state_q == ST_FRAME || last_bit)) begin
			shift_q <= {shift_q[30:0], 1'b0};
		end
		// PHY drives data bits 16..31
		if (rise && state_q == ST_FRAME && bit_cnt_q[4] && op_q == MDIO_READ)
			rdata_q <= {rdata_q[14:0], mdio_i};
	end

	assign mdc_o       = mdc_q;
	assign mdio_o      = mdio_q;
	assign mdio_oe_o   = oe_q;
	assign rsp_o.done  = done_q;
	assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/nic_pkg.sv
`default_nettype none

package nic_pkg;

	typedef logic [11:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	// Mapped register offsets
	typedef enum axil_addr_t {
		CTRL = 12'h000,
		MDIC = 12'h020,
		ICR  = 12'h0C0,
		ICS  = 12'h0C8,
		IMS  = 12'h0D0,
		IMC  = 12'h0D8
	} reg_addr_e;

	localparam int CTRL_RST_BIT     = 26;
	localparam int CTRL_PHY_RST_BIT = 31;

	localparam int ICR_MDAC_BIT   = 9;
	localparam int ICR_PHYINT_BIT = 12;

	// MDIC fields above the 16-bit data
	localparam int MDIC_REG_LSB = 16;
	localparam int MDIC_OP_LSB  = 26;
	localparam int MDIC_R_BIT   = 28;

	typedef enum logic [1:0] {
		MDIO_WRITE = 2'b01,
		MDIO_READ  = 2'b10
	} mdio_op_e;

	typedef struct packed {
		logic       valid;
		logic       write;
		axil_addr_t addr;
		axil_data_t wdata;
		logic [3:0] wstrb;
	} reg_req_t;

	typedef struct packed {
		logic       ics_set;
		logic       ims_set;
		logic       imc_set;
		logic       icr_rd;
		axil_data_t data; // Already masked by strobes
	} intr_cmd_t;

	typedef struct packed {
		axil_data_t icr;
		axil_data_t ims;
	} intr_stat_t;

	typedef struct packed {
		logic        start;
		mdio_op_e    op;
		logic [4:0]  reg_addr;
		logic [15:0] wdata;
	} mdio_cmd_t;

	typedef struct packed {
		logic        done;
		logic [15:0] rdata;
	} mdio_rsp_t;

endpackage

`default_nettype wire

// File: src/nic_regs.sv
`timescale 1ns/1ps
`default_nettype none

module nic_regs (
	input  logic                aclk,
	input  logic                arst_n_i,

	input  nic_pkg::reg_req_t   req_i,
	output nic_pkg::axil_data_t rdata_o,

	output nic_pkg::intr_cmd_t  intr_cmd_o,
	input  nic_pkg::intr_stat_t intr_stat_i,

	output nic_pkg::mdio_cmd_t  mdio_cmd_o,
	input  nic_pkg::mdio_rsp_t  mdio_rsp_i,

	output logic                reset_request_o,
	output logic                phy_reset_o
);
	import nic_pkg::*;

	axil_data_t ctrl_q;
	axil_data_t mdic_q;
	axil_data_t wmask;
	axil_data_t ctrl_wr;
	axil_data_t mdic_wr;
	mdio_op_e   mdic_op;
	logic       wr_en;
	logic       rd_en;
	logic       mdic_wr_en;
	logic       mdic_start;

	assign wr_en = req_i.valid & req_i.write;
	assign rd_en = req_i.valid & ~req_i.write;

	assign wmask = {{8{req_i.wstrb[3]}}, {8{req_i.wstrb[2]}},
		{8{req_i.wstrb[1]}}, {8{req_i.wstrb[0]}}};

	// Disabled lanes keep the old byte
	assign ctrl_wr = (ctrl_q & ~wmask) | (req_i.wdata & wmask);
	assign mdic_wr = (mdic_q & ~wmask) | (req_i.wdata & wmask);
	assign mdic_op = mdio_op_e'(mdic_wr[MDIC_OP_LSB +: 2]);

	// Busy MDIC ignores writes
	assign mdic_wr_en = wr_en && req_i.addr == MDIC && mdic_q[MDIC_R_BIT];
	assign mdic_start = mdic_wr_en && (mdic_op == MDIO_WRITE || mdic_op == MDIO_READ);

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i)
			ctrl_q <= '0;
		else if (wr_en && req_i.addr == CTRL)
			ctrl_q <= ctrl_wr;
	end

	always_ff @(posedge aclk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mdic_q <= axil_data_t'(1) << MDIC_R_BIT; // Ready out of reset
		end else if (mdio_rsp_i.done) begin
			mdic_q[MDIC_R_BIT] <= 1'b1;
			if (mdic_q[MDIC_OP_LSB +: 2] == MDIO_READ)
				mdic_q[15:0] <= mdio_rsp_i.rdata;
		end else if (mdic_wr_en) begin
			mdic_q             <= mdic_wr;
			mdic_q[MDIC_R_BIT] <= ~mdic_start;
		end
	end

	always_comb begin
		intr_cmd_o.ics_set = wr_en && req_i.addr == ICS;
		intr_cmd_o.ims_set = wr_en && req_i.addr == IMS;
		intr_cmd_o.imc_set = wr_en && req_i.addr == IMC;
		intr_cmd_o.icr_rd  = rd_en && req_i.addr == ICR; // Clear on read
		intr_cmd_o.data    = req_i.wdata & wmask;
	end

	always_comb begin
		mdio_cmd_o.start    = mdic_start;
		mdio_cmd_o.op       = mdic_op;
		mdio_cmd_o.reg_addr = mdic_wr[MDIC_REG_LSB +: 5];
		mdio_cmd_o.wdata    = mdic_wr[15:0];
	end

	always_comb begin
		case (req_i.addr)
			CTRL:    rdata_o = ctrl_q;
			MDIC:    rdata_o = mdic_q;
			ICR:     rdata_o = intr_stat_i.icr;
			IMS:     rdata_o = intr_stat_i.ims;
			default: rdata_o = '0; // ICS, IMC and holes
		endcase
	end

	assign reset_request_o = ctrl_q[CTRL_RST_BIT];
	assign phy_reset_o     = ctrl_q[CTRL_PHY_RST_BIT] | ~arst_n_i;

endmodule

`default_nettype wire

// File: src/nic_top.sv
`timescale 1ns/1ps
`default_nettype none

module nic_top #(
	parameter logic [4:0] PHY_ADDR = 5'd0,
	parameter int         MDC_DIV  = 2
) (
	input  logic                aclk,
	input  logic                arst_n_i,

	input  nic_pkg::axil_addr_t axil_awaddr_i,
	input  logic                axil_awvalid_i,
	output logic                axil_awready_o,
	input  nic_pkg::axil_data_t axil_wdata_i,
	input  logic [3:0]          axil_wstrb_i,
	input  logic                axil_wvalid_i,
	output logic                axil_wready_o,
	output logic                axil_bvalid_o,
	output logic [1:0]          axil_bresp_o,
	input  logic                axil_bready_i,
	input  nic_pkg::axil_addr_t axil_araddr_i,
	input  logic                axil_arvalid_i,
	output logic                axil_arready_o,
	output logic                axil_rvalid_o,
	output nic_pkg::axil_data_t axil_rdata_o,
	output logic [1:0]          axil_rresp_o,
	input  logic                axil_rready_i,

	output logic                intr_o,
	output logic                reset_request_o,
	output logic                phy_reset_o,

	output logic                mdc_o,
	input  logic                mdio_i,
	output logic                mdio_o,
	output logic                mdio_oe_o,
	input  logic                phy_int_i
);
	import nic_pkg::*;

	reg_req_t   reg_req;
	axil_data_t reg_rdata;
	intr_cmd_t  intr_cmd;
	intr_stat_t intr_stat;
	mdio_cmd_t  mdio_cmd;
	mdio_rsp_t  mdio_rsp;

	nic_axil_slave axil_slave_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.s_awaddr_i(axil_awaddr_i), .s_awvalid_i(axil_awvalid_i), .s_awready_o(axil_awready_o),
		.s_wdata_i(axil_wdata_i), .s_wstrb_i(axil_wstrb_i),
		.s_wvalid_i(axil_wvalid_i), .s_wready_o(axil_wready_o),
		.s_bvalid_o(axil_bvalid_o), .s_bresp_o(axil_bresp_o), .s_bready_i(axil_bready_i),
		.s_araddr_i(axil_araddr_i), .s_arvalid_i(axil_arvalid_i), .s_arready_o(axil_arready_o),
		.s_rvalid_o(axil_rvalid_o), .s_rdata_o(axil_rdata_o),
		.s_rresp_o(axil_rresp_o), .s_rready_i(axil_rready_i),
		.req_o(reg_req), .rdata_i(reg_rdata)
	);

	nic_regs regs_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.req_i(reg_req), .rdata_o(reg_rdata),
		.intr_cmd_o(intr_cmd), .intr_stat_i(intr_stat),
		.mdio_cmd_o(mdio_cmd), .mdio_rsp_i(mdio_rsp),
		.reset_request_o(reset_request_o), .phy_reset_o(phy_reset_o)
	);

	nic_intr_ctrl intr_ctrl_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.cmd_i(intr_cmd), .mdac_i(mdio_rsp.done), // MDIO completion cause
		.phy_int_i(phy_int_i), .stat_o(intr_stat), .intr_o(intr_o)
	);

	nic_mdio_master #(.PHY_ADDR(PHY_ADDR), .MDC_DIV(MDC_DIV)) mdio_master_i (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.cmd_i(mdio_cmd), .rsp_o(mdio_rsp),
		.mdc_o(mdc_o), .mdio_i(mdio_i), .mdio_o(mdio_o), .mdio_oe_o(mdio_oe_o)
	);

endmodule

`default_nettype wire

// File: testbench/nic_axil_sva.sv
`timescale 1ns/1ps
`default_nettype none

module nic_axil_sva (
	input  logic aclk,
	input  logic arst_n_i,
	input  logic s_awready_o,
	input  logic s_wready_o,
	input  logic s_arready_o,
	input  logic s_bvalid_o,
	input  logic s_bready_i,
	input  logic s_rvalid_o,
	input  logic s_rready_i
);
	int fail_count = 0;

	a_b_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o)
		else begin
			fail_count <= fail_count + 1;
			$error("bvalid dropped before bready");
		end

	a_r_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o)
		else begin
			fail_count <= fail_count + 1;
			$error("rvalid dropped before rready");
		end

	// One write response at a time
	a_aw_blocked: assert property (@(posedge aclk) disable iff (!arst_n_i)
		s_bvalid_o |-> !s_awready_o && !s_wready_o)
		else begin
			fail_count <= fail_count + 1;
			$error("awready high with a B response pending");
		end

	a_reset_quiet: assert property (@(posedge aclk)
		!arst_n_i |-> !s_bvalid_o && !s_rvalid_o)
		else begin
			fail_count <= fail_count + 1;
			$error("valid output high during reset");
		end

endmodule

bind nic_axil_slave nic_axil_sva axil_sva_i (.*);

`default_nettype wire

// File: testbench/nic_checker.sv
`timescale 1ns/1ps
`default_nettype none

module nic_checker #(
	parameter logic [4:0] PHY_ADDR = 5'd0
) (
	input  logic        aclk,
	input  logic        arst_n_i,
	input  logic [11:0] awaddr_i,
	input  logic        awvalid_i,
	input  logic        awready_i,
	input  logic [31:0] wdata_i,
	input  logic [3:0]  wstrb_i,
	input  logic        wready_i,
	input  logic        bvalid_i,
	input  logic [1:0]  bresp_i,
	input  logic        bready_i,
	input  logic [11:0] araddr_i,
	input  logic        arvalid_i,
	input  logic        arready_i,
	input  logic        rvalid_i,
	input  logic [31:0] rdata_i,
	input  logic [1:0]  rresp_i,
	input  logic        rready_i,
	input  logic        intr_i,
	input  logic        reset_request_i,
	input  logic        phy_reset_i,
	input  logic        mdc_i,
	input  logic        mdio_oe_i,
	input  logic        phy_int_i,
	input  int          frame_cnt_i,
	input  logic [1:0]  frame_op_i,
	input  logic [4:0]  frame_phy_i,
	input  logic [4:0]  frame_reg_i,
	input  logic [15:0] frame_data_i,
	input  logic [15:0] phy_rdata_i,
	output int          err_count_o
);
	import nic_pkg::*;

	logic [31:0] ctrl_m;
	logic [31:0] mdic_m;
	logic [31:0] icr_m;
	logic [31:0] ims_m;
	logic [31:0] exp_q[$];
	logic [11:0] addr_q[$];
	logic        poll_q[$];
	logic        busy;
	logic [1:0]  pend_op;
	logic [4:0]  pend_reg;
	logic [15:0] pend_data;
	logic        intr_exp;
	int          intr_stage;
	int          errors = 0;
	int          b_count = 0;
	int          r_count = 0;
	int          starts = 0;
	int          frames = 0;
	int          last_frame = 0;

	assign err_count_o = errors;

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		errors++;
		$display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
	endtask

	function automatic logic [31:0] lane_mask(input logic [3:0] strb);
		return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	endfunction

	task automatic apply_write(input logic [11:0] addr, input logic [31:0] d,
		input logic [3:0] strb);
		logic [31:0] m;
		logic [31:0] nw;
		m = lane_mask(strb);
		case (addr)
			CTRL: ctrl_m = (ctrl_m & ~m) | (d & m);
			MDIC: begin
				nw = (mdic_m & ~m) | (d & m);
				if (!busy) begin
					nw[28] = !(nw[27:26] == 2'b01 || nw[27:26] == 2'b10);
					if (!nw[28]) begin
						busy      = 1'b1;
						starts++;
						pend_op   = nw[27:26];
						pend_reg  = nw[20:16];
						pend_data = nw[15:0];
					end
					mdic_m = nw;
				end
			end
			ICS: icr_m = icr_m | (d & m);
			IMS: ims_m = ims_m | (d & m);
			IMC: ims_m = ims_m & ~(d & m);
			default: ;
		endcase
	endtask

	task automatic record_read(input logic [11:0] addr);
		logic [31:0] exp;
		exp = '0;
		case (addr)
			CTRL: exp = ctrl_m;
			MDIC: exp = mdic_m;
			ICR: begin
				exp   = icr_m;
				icr_m = '0; // Clear on read
			end
			IMS: exp = ims_m;
			default: ;
		endcase
		exp_q.push_back(exp);
		addr_q.push_back(addr);
		poll_q.push_back(addr == MDIC && busy);
	endtask

	task automatic check_read(input logic [31:0] act);
		logic [31:0] exp;
		logic [11:0] addr;
		logic        poll;
		r_count++;
		if (exp_q.size() == 0) begin
			errors++;
			$display("R response arrived with no read outstanding");
		end else begin
			exp  = exp_q.pop_front();
			addr = addr_q.pop_front();
			poll = poll_q.pop_front();
			// Frame finished while this read was in flight
			if (poll && act[28]) begin
				exp[28] = 1'b1;
				if (pend_op == 2'b10)
					exp[15:0] = phy_rdata_i;
				busy      = 1'b0;
				mdic_m    = exp;
				icr_m[9]  = 1'b1;
			end
			if (act !== exp)
				report_mismatch($sformatf("rdata @0x%03h", addr), exp, act);
		end
	endtask

	task automatic check_frame();
		frames++;
		last_frame = frame_cnt_i;
		if (!busy) begin
			errors++;
			$display("MDIO frame seen with no MDIC request pending");
		end
		if (frame_op_i !== pend_op)
			report_mismatch("mdio op", 32'(pend_op), 32'(frame_op_i));
		if (frame_phy_i !== PHY_ADDR)
			report_mismatch("mdio phy address", 32'(PHY_ADDR), 32'(frame_phy_i));
		if (frame_reg_i !== pend_reg)
			report_mismatch("mdio register", 32'(pend_reg), 32'(frame_reg_i));
		if (pend_op == 2'b01 && frame_data_i !== pend_data)
			report_mismatch("mdio write data", 32'(pend_data), 32'(frame_data_i));
	endtask

	always @(posedge aclk) begin
		if (!arst_n_i) begin
			ctrl_m     = '0;
			mdic_m     = 32'h1000_0000;
			icr_m      = '0;
			ims_m      = '0;
			busy       = 1'b0;
			intr_stage = 0;
			if (bvalid_i || rvalid_i || awready_i || wready_i || arready_i || intr_i) begin
				errors++;
				$display("AXI valid, ready or interrupt output high during reset");
			end
			if (!phy_reset_i || mdc_i || mdio_oe_i) begin
				errors++;
				$display("PHY reset, MDC or MDIO enable wrong during reset");
			end
		end else begin
			if (reset_request_i !== ctrl_m[CTRL_RST_BIT])
				report_mismatch("reset_request_o", 32'(ctrl_m[CTRL_RST_BIT]),
					32'(reset_request_i));
			if (phy_reset_i !== ctrl_m[CTRL_PHY_RST_BIT])
				report_mismatch("phy_reset_o", 32'(ctrl_m[CTRL_PHY_RST_BIT]),
					32'(phy_reset_i));
			if (intr_stage == 1 && intr_i !== intr_exp)
				report_mismatch("intr_o", 32'(intr_exp), 32'(intr_i));
			if (intr_stage != 0)
				intr_stage--;
			if (phy_int_i)
				icr_m[ICR_PHYINT_BIT] = 1'b1;
			if (frame_cnt_i != last_frame)
				check_frame();
			if (bvalid_i && bready_i) begin
				b_count++;
				if (bresp_i !== 2'b00) // OKAY only
					report_mismatch("bresp", 32'h0, 32'(bresp_i));
			end
			if (rvalid_i && rready_i) begin
				if (rresp_i !== 2'b00)
					report_mismatch("rresp", 32'h0, 32'(rresp_i));
				check_read(rdata_i);
			end
			if (awvalid_i && awready_i) begin
				apply_write(awaddr_i, wdata_i, wstrb_i);
				intr_exp   = |(icr_m & ims_m);
				intr_stage = 2; // intr_o settles one cycle after bvalid
			end
			if (arvalid_i && arready_i)
				record_read(araddr_i);
		end
	end

	task automatic final_check(input int n_wr, input int n_rd);
		if (b_count != n_wr)
			report_mismatch("B handshake count", 32'(n_wr), 32'(b_count));
		if (r_count != n_rd)
			report_mismatch("R handshake count", 32'(n_rd), 32'(r_count));
		if (frames != starts)
			report_mismatch("MDIO frame count", 32'(starts), 32'(frames));
		if (exp_q.size() != 0) begin
			errors++;
			$display("Read responses still outstanding at the end");
		end
	endtask

endmodule

`default_nettype wire

// File: testbench/tb_nic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nic;
	import nic_pkg::*;

	localparam logic [4:0] PHY_ADDR = 5'h05;
	localparam int         MDC_DIV  = 2;
	localparam int         N_OPS    = 200;
	localparam int         N_MDIO   = 20;
	// Register ops with stalls, then frames with their MDIC polling
	localparam int TIMEOUT = N_OPS * 20 + N_MDIO * (2 * 128 * MDC_DIV + 200) + 500;

	logic        aclk;
	logic        arst_n_i;
	logic [11:0] axil_awaddr_i;
	logic        axil_awvalid_i;
	logic        axil_awready_o;
	logic [31:0] axil_wdata_i;
	logic [3:0]  axil_wstrb_i;
	logic        axil_wvalid_i;
	logic        axil_wready_o;
	logic        axil_bvalid_o;
	logic [1:0]  axil_bresp_o;
	logic        axil_bready_i;
	logic [11:0] axil_araddr_i;
	logic        axil_arvalid_i;
	logic        axil_arready_o;
	logic        axil_rvalid_o;
	logic [31:0] axil_rdata_o;
	logic [1:0]  axil_rresp_o;
	logic        axil_rready_i;
	logic        intr_o;
	logic        reset_request_o;
	logic        phy_reset_o;
	logic        mdc_o;
	logic        mdio_i;
	logic        mdio_o;
	logic        mdio_oe_o;
	logic        phy_int_i;

	int          seed = 32'hade8_7926;
	int          cycles = 0;
	int          n_wr = 0;
	int          n_rd = 0;
	int          chk_errors;
	int          total_errors;
	logic [11:0] addr_pool [8] = '{12'h000, 12'h0D0, 12'h0D8, 12'h0C8,
		12'h0C0, 12'h004, 12'h0FC, 12'h7F0};

	// PHY side
	logic [15:0] phy_table [32];
	int          ones = 0;
	int          pos = 0;
	logic [31:0] frame;
	logic        frame_rd;
	logic [15:0] phy_rdata = '0;
	int          frame_cnt = 0;
	logic [1:0]  frame_op;
	logic [4:0]  frame_phy;
	logic [4:0]  frame_reg;
	logic [15:0] frame_data;

	nic_top #(.PHY_ADDR(PHY_ADDR), .MDC_DIV(MDC_DIV)) uut (.*);

	nic_checker #(.PHY_ADDR(PHY_ADDR)) chk (
		.aclk(aclk), .arst_n_i(arst_n_i),
		.awaddr_i(axil_awaddr_i), .awvalid_i(axil_awvalid_i), .awready_i(axil_awready_o),
		.wdata_i(axil_wdata_i), .wstrb_i(axil_wstrb_i), .wready_i(axil_wready_o),
		.bvalid_i(axil_bvalid_o), .bresp_i(axil_bresp_o), .bready_i(axil_bready_i),
		.araddr_i(axil_araddr_i), .arvalid_i(axil_arvalid_i), .arready_i(axil_arready_o),
		.rvalid_i(axil_rvalid_o), .rdata_i(axil_rdata_o), .rresp_i(axil_rresp_o),
		.rready_i(axil_rready_i),
		.intr_i(intr_o), .reset_request_i(reset_request_o), .phy_reset_i(phy_reset_o),
		.mdc_i(mdc_o), .mdio_oe_i(mdio_oe_o), .phy_int_i(phy_int_i),
		.frame_cnt_i(frame_cnt), .frame_op_i(frame_op), .frame_phy_i(frame_phy),
		.frame_reg_i(frame_reg), .frame_data_i(frame_data), .phy_rdata_i(phy_rdata),
		.err_count_o(chk_errors)
	);

	initial begin
		aclk = 1'b0;
		forever #10 aclk = ~aclk;
	end

	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge aclk);
			cycles++;
		end
		$display("Timeout: test did not finish within %0d cycles", TIMEOUT);
		$display("Done: errors found");
		$finish;
	end

	// PHY model decoding frames on MDC rising edges
	always @(posedge mdc_o) begin
		if (pos == 0) begin
			if (mdio_oe_o && mdio_o) begin
				ones = ones + 1;
			end else if (mdio_oe_o && ones >= 32) begin
				pos   = 1; // Start bit 0 seen
				frame = '0;
			end else begin
				ones = 0;
			end
		end else begin
			frame = {frame[30:0], mdio_oe_o ? mdio_o : mdio_i};
			if (pos == 13) begin
				frame_rd = frame[11:10] == 2'b10;
				if (frame_rd)
					phy_rdata = phy_table[frame[4:0]];
			end
			if (frame_rd && pos >= 15 && pos <= 30)
				mdio_i <= #2 phy_rdata[30 - pos];
			if (pos == 31) begin
				frame_op   = frame[29:28];
				frame_phy  = frame[27:23];
				frame_reg  = frame[22:18];
				frame_data = frame[15:0];
				if (frame_op == 2'b01)
					phy_table[frame_reg] = frame_data;
				frame_cnt = frame_cnt + 1;
				mdio_i <= #2 1'b1;
				pos  = 0;
				ones = 0;
			end else begin
				pos = pos + 1;
			end
		end
	end

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int   rnd;
		logic done;
		axil_awaddr_i  = addr;
		axil_wdata_i   = data;
		axil_wstrb_i   = strb;
		axil_awvalid_i = 1'b1;
		axil_wvalid_i  = 1'b1;
		@(posedge aclk);
		while (!axil_awready_o)
			@(posedge aclk);
		#2;
		axil_awvalid_i = 1'b0;
		axil_wvalid_i  = 1'b0;
		n_wr++;
		done = 1'b0;
		while (!done) begin
			rnd = $random(seed);
			axil_bready_i = rnd[0]; // Random back-pressure
			@(posedge aclk);
			done = axil_bvalid_o && axil_bready_i;
			#2;
		end
		axil_bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr, output logic [31:0] data);
		int   rnd;
		logic done;
		axil_araddr_i  = addr;
		axil_arvalid_i = 1'b1;
		@(posedge aclk);
		while (!axil_arready_o)
			@(posedge aclk);
		#2;
		axil_arvalid_i = 1'b0;
		n_rd++;
		done = 1'b0;
		while (!done) begin
			rnd = $random(seed);
			axil_rready_i = rnd[0];
			@(posedge aclk);
			done = axil_rvalid_o && axil_rready_i;
			data = axil_rdata_o;
			#2;
		end
		axil_rready_i = 1'b0;
	endtask

	task automatic pulse_phy_int();
		logic [31:0] rd;
		phy_int_i = 1'b1;
		repeat (4) @(posedge aclk);
		#2;
		phy_int_i = 1'b0;
		repeat (8) @(posedge aclk); // Let the synchronizer settle
		#2;
		axi_read(ICR, rd);
		axi_read(ICR, rd);
	endtask

	initial begin
		int          rnd;
		int          rnd2;
		logic [31:0] rdata;
		logic [31:0] cmd;
		logic [1:0]  op;
		arst_n_i       = 1'b0;
		axil_awaddr_i  = '0;
		axil_awvalid_i = 1'b0;
		axil_wdata_i   = '0;
		axil_wstrb_i   = '0;
		axil_wvalid_i  = 1'b0;
		axil_bready_i  = 1'b0;
		axil_araddr_i  = '0;
		axil_arvalid_i = 1'b0;
		axil_rready_i  = 1'b0;
		mdio_i         = 1'b1;
		phy_int_i      = 1'b0;
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			phy_table[i] = rnd[15:0];
		end
		repeat (5) @(posedge aclk);
		#2;
		arst_n_i = 1'b1;
		@(posedge aclk);
		#2;

		for (int i = 0; i < N_OPS; i++) begin
			rnd  = $random(seed);
			rnd2 = $random(seed);
			if (rnd[3])
				axi_write(addr_pool[rnd[2:0]], rnd2, rnd[7:4]);
			else
				axi_read(addr_pool[rnd[2:0]], rdata);
			if (i % 25 == 24)
				pulse_phy_int();
		end

		for (int i = 0; i < N_MDIO; i++) begin
			rnd  = $random(seed);
			rnd2 = $random(seed);
			op   = rnd[0] ? 2'b10 : 2'b01;
			cmd  = {4'b0000, op, 5'b00000, rnd[20:16], rnd2[15:0]};
			axi_write(MDIC, cmd, 4'hF);
			axi_write(MDIC, cmd ^ 32'h001F_FFFF, 4'hF); // Busy, must be dropped
			rdata = '0;
			while (!rdata[MDIC_R_BIT])
				axi_read(MDIC, rdata);
			axi_read(ICR, rdata);
		end

		repeat (4) @(posedge aclk);
		chk.final_check(n_wr, n_rd);
		#1;
		total_errors = chk_errors + uut.axil_slave_i.axil_sva_i.fail_count;
		$display("Errors: %0d, writes %0d, reads %0d, frames %0d, cycles %0d",
			total_errors, n_wr, n_rd, frame_cnt, cycles);
		if (total_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
